// File: rtl/board_pkg.sv
package board_pkg;

    typedef enum logic [2:0] {
        DEV_NONE,
        DEV_ROM,
        DEV_RAM,
        DEV_PAL,
        DEV_OBJ,
        DEV_CAB,
        DEV_IOLO,
        DEV_IOHI
    } dev_t;

    typedef struct packed {
        logic [23:1] addr;   // word address
        logic [15:0] wdata;
        logic        we;
        logic [ 1:0] dsn;    // {UDSn, LDSn}
    } bus_req_t;

    typedef struct packed {
        logic [15:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic [19:1] addr;
        logic [15:0] wdata;
        logic        we;
        logic [ 1:0] dsn;
    } ext_bus_t;

    typedef struct packed {
        logic [2:0] cbnk;
        logic       dimpol;
        logic       dimmod;
        logic       eep_clk;
        logic       eep_cs;
        logic       eep_di;
    } iolo_t;

    typedef struct packed {
        logic [2:0] dim;
        logic       rmrd;
    } iohi_t;

    typedef enum logic [1:0] {
        EOP_EXT   = 2'b00,   // EWEN/EWDS by address MSBs
        EOP_WRITE = 2'b01,
        EOP_READ  = 2'b10,
        EOP_ERASE = 2'b11
    } eep_op_t;

    localparam logic [15:0] UNMAPPED_DATA = 16'hffff;

    // memory map fields
    localparam logic [3:0] REGION_ROM  = 4'h0;   // addr[23:20]
    localparam logic [3:0] REGION_MAIN = 4'h1;
    localparam logic [1:0] MAIN_RAM    = 2'd0;   // addr[19:18]
    localparam logic [1:0] MAIN_PAL    = 2'd1;
    localparam logic [1:0] MAIN_OBJ    = 2'd2;
    localparam logic [1:0] MAIN_IO     = 2'd3;
    localparam logic [3:0] IO_CAB0     = 4'h0;   // addr[11:8]
    localparam logic [3:0] IO_CAB1     = 4'h1;
    localparam logic [3:0] IO_LO       = 4'h2;
    localparam logic [3:0] IO_HI       = 4'h3;

endpackage

// File: rtl/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder (
    input  logic [23:1]     addr,
    output board_pkg::dev_t dev
);
    import board_pkg::*;

    always_comb begin
        dev = DEV_NONE;
        case (addr[23:20])
            REGION_ROM: begin
                dev = DEV_ROM;
            end
            REGION_MAIN: begin
                case (addr[19:18])
                    MAIN_RAM: dev = DEV_RAM;
                    MAIN_PAL: dev = DEV_PAL;
                    MAIN_OBJ: dev = DEV_OBJ;
                    MAIN_IO: begin
                        // io page decoded on the middle nibble
                        case (addr[11:8])
                            IO_CAB0, IO_CAB1: dev = DEV_CAB;
                            IO_LO:            dev = DEV_IOLO;
                            IO_HI:            dev = DEV_IOHI;
                            default:          dev = DEV_NONE;
                        endcase
                    end
                    default: dev = DEV_NONE;
                endcase
            end
            default: dev = DEV_NONE;
        endcase
    end

endmodule

// File: rtl/bus_cycle_ctrl.sv
`timescale 1ns/1ps

module bus_cycle_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  board_pkg::bus_req_t   req,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output board_pkg::bus_rsp_t   rsp,
    input  logic                  rsp_ready,
    output board_pkg::ext_bus_t   ext,
    output logic [23:1]           addr_q,
    output logic                  rom_cs,
    output logic                  ram_cs,
    output logic                  pal_cs,
    output logic                  obj_cs,
    input  logic [15:0]           rom_data,
    input  logic                  rom_ok,
    input  logic [15:0]           ram_dout,
    input  logic                  ram_ok,
    input  logic [15:0]           pal_dout,
    input  logic [15:0]           obj_dout,
    input  logic [ 7:0]           cab_dout,
    output logic                  iolo_we,
    output logic                  iohi_we,
    output logic [15:0]           wdata_q
);
    import board_pkg::*;

    typedef enum logic [1:0] {IDLE, SEL, WAIT, RESP} state_t;

    state_t      state;
    bus_req_t    req_q;
    dev_t        dev;
    dev_t        dev_q;
    logic        dly;       // rom/ram results take one more turn
    logic        hit;
    logic [15:0] sel_data;

    addr_decoder u_dec (
        .addr ( req_q.addr ),
        .dev  ( dev        )
    );

    assign req_ready = state == IDLE;
    assign addr_q    = req_q.addr;
    assign wdata_q   = req_q.wdata;
    assign ext       = '{addr: req_q.addr[19:1], wdata: req_q.wdata,
                         we: req_q.we, dsn: req_q.dsn};

    // rom and ram wait for ok, the rest answer on the first wait cycle
    assign hit = dev_q == DEV_ROM ? rom_ok :
                 dev_q == DEV_RAM ? ram_ok : 1'b1;

    always_comb begin
        case (dev_q)
            DEV_ROM: sel_data = rom_data;
            DEV_RAM: sel_data = ram_dout;
            DEV_PAL: sel_data = pal_dout;
            DEV_OBJ: sel_data = obj_dout;
            DEV_CAB: sel_data = {8'h00, cab_dout};
            default: sel_data = UNMAPPED_DATA;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready)
            req_q <= req;
        if (state == WAIT && hit)
            rsp <= '{rdata: sel_data};
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            dev_q     <= DEV_NONE;
            dly       <= 1'b0;
            rsp_valid <= 1'b0;
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            pal_cs    <= 1'b0;
            obj_cs    <= 1'b0;
            iolo_we   <= 1'b0;
            iohi_we   <= 1'b0;
        end else begin
            iolo_we <= 1'b0;
            iohi_we <= 1'b0;
            case (state)
                IDLE: if (req_valid) state <= SEL;
                SEL: begin
                    dev_q  <= dev;
                    rom_cs <= dev == DEV_ROM;
                    ram_cs <= dev == DEV_RAM;
                    pal_cs <= dev == DEV_PAL;
                    obj_cs <= dev == DEV_OBJ;
                    state  <= WAIT;
                end
                WAIT: if (hit) begin
                    rom_cs  <= 1'b0;
                    ram_cs  <= 1'b0;
                    pal_cs  <= 1'b0;
                    obj_cs  <= 1'b0;
                    dly     <= dev_q == DEV_ROM || dev_q == DEV_RAM;
                    iolo_we <= req_q.we && dev_q == DEV_IOLO;
                    iohi_we <= req_q.we && dev_q == DEV_IOHI;
                    state   <= RESP;
                end
                RESP: begin
                    if (!rsp_valid) begin
                        rsp_valid <= !dly;
                        dly       <= 1'b0;
                    end else if (rsp_ready) begin
                        rsp_valid <= 1'b0;   // response taken
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: rtl/cab_inputs.sv
`timescale 1ns/1ps

module cab_inputs (
    input  logic        clk,
    input  logic        rst,
    input  logic [23:1] addr_q,
    input  logic [ 6:0] joystick1,
    input  logic [ 6:0] joystick2,
    input  logic [ 1:0] cab_1p,
    input  logic [ 1:0] coin,
    input  logic [ 1:0] service,
    input  logic        dip_test,
    input  logic        lvbl,
    input  logic        eep_do,
    input  logic        eep_rdy,
    output logic [ 7:0] cab_dout
);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cab_dout <= 8'h00;
        end else begin
            case (addr_q[2:1])
                2'd0: cab_dout <= {cab_1p[0], joystick1};
                2'd1: cab_dout <= {cab_1p[1], joystick2};
                2'd2: cab_dout <= {service, coin, 4'hf};
                // status byte, eeprom serial out in bit 0
                default: cab_dout <= {dip_test, 3'b111, lvbl, 1'b1, eep_rdy, eep_do};
            endcase
        end
    end

endmodule

// File: rtl/io_latches.sv
`timescale 1ns/1ps

module io_latches (
    input  logic             clk,
    input  logic             rst,
    input  logic             iolo_we,
    input  logic             iohi_we,
    input  logic [15:0]      wdata_q,
    output board_pkg::iolo_t iolo,
    output board_pkg::iohi_t iohi
);
    import board_pkg::*;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            iolo <= '0;
            iohi <= '0;
        end else begin
            if (iolo_we)
                iolo <= iolo_t'(wdata_q[7:0]);   // colour bank, dimming, eeprom pins
            if (iohi_we)
                iohi <= iohi_t'(wdata_q[6:3]);
        end
    end

endmodule

// File: rtl/serial_eeprom.sv
`timescale 1ns/1ps

module serial_eeprom #(
    parameter int WRITE_CYCLES = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       sclk,
    input  logic       scs,
    input  logic       sdi,
    output logic       sdo,
    output logic       rdy,
    input  logic [6:0] mem_addr,
    output logic [7:0] mem_dout,
    input  logic [7:0] mem_din,
    input  logic       mem_we
);
    import board_pkg::*;

    localparam int BW = $clog2(WRITE_CYCLES + 1);

    typedef enum logic [2:0] {E_IDLE, E_OP, E_ADDR, E_DATA, E_READ, E_BUSY} estate_t;

    estate_t     st;
    eep_op_t     op;
    logic [ 5:0] ea;
    logic [ 5:0] a_next;
    logic [15:0] sreg;      // shifts data in, and out on reads
    logic [ 3:0] cnt;
    logic [BW-1:0] busy_cnt;
    logic        ewen;
    logic        wr_pend;   // write done, busy once cs drops
    logic        wr_stb;
    logic [ 5:0] wr_addr;
    logic [15:0] wr_val;
    logic        sclk_l;
    logic        rise;
    logic [15:0] rd_word;
    logic [ 7:0] mem [0:127];

    assign rise    = sclk & ~sclk_l;
    assign a_next  = {ea[4:0], sdi};
    assign rd_word = {mem[{a_next, 1'b1}], mem[{a_next, 1'b0}]};
    assign rdy     = st != E_BUSY;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            st       <= E_IDLE;
            op       <= EOP_EXT;
            ea       <= '0;
            sreg     <= '0;
            cnt      <= '0;
            busy_cnt <= '0;
            ewen     <= 1'b0;
            wr_pend  <= 1'b0;
            wr_stb   <= 1'b0;
            wr_addr  <= '0;
            wr_val   <= '0;
            sclk_l   <= 1'b0;
            sdo      <= 1'b0;
        end else begin
            sclk_l <= sclk;
            wr_stb <= 1'b0;
            if (st == E_BUSY) begin
                if (busy_cnt == '0)
                    st <= E_IDLE;
                else
                    busy_cnt <= busy_cnt - 1'b1;
            end else if (!scs) begin
                sdo <= 1'b0;
                cnt <= '0;
                if (wr_pend) begin
                    st       <= E_BUSY;
                    busy_cnt <= BW'(WRITE_CYCLES - 1);
                    wr_pend  <= 1'b0;
                end else begin
                    st <= E_IDLE;
                end
            end else if (rise) begin
                case (st)
                    E_IDLE: if (sdi) begin   // start bit
                        st  <= E_OP;
                        cnt <= '0;
                    end
                    E_OP: begin
                        op  <= eep_op_t'({op[0], sdi});
                        cnt <= cnt + 1'b1;
                        if (cnt == 4'd1) begin
                            st  <= E_ADDR;
                            cnt <= '0;
                        end
                    end
                    E_ADDR: begin
                        ea  <= a_next;
                        cnt <= cnt + 1'b1;
                        if (cnt == 4'd5) begin
                            cnt <= '0;
                            case (op)
                                EOP_READ: begin
                                    sreg <= rd_word;
                                    sdo  <= 1'b0;   // dummy bit first
                                    st   <= E_READ;
                                end
                                EOP_WRITE: st <= E_DATA;
                                EOP_ERASE: begin
                                    if (ewen) begin
                                        wr_stb  <= 1'b1;
                                        wr_addr <= a_next;
                                        wr_val  <= 16'hffff;
                                        wr_pend <= 1'b1;
                                    end
                                    st <= E_IDLE;
                                end
                                default: begin
                                    if (a_next[5:4] == 2'b11)
                                        ewen <= 1'b1;   // EWEN
                                    else if (a_next[5:4] == 2'b00)
                                        ewen <= 1'b0;   // EWDS
                                    st <= E_IDLE;
                                end
                            endcase
                        end
                    end
                    E_DATA: begin
                        sreg <= {sreg[14:0], sdi};
                        cnt  <= cnt + 1'b1;
                        if (cnt == 4'd15) begin
                            if (ewen) begin
                                wr_stb  <= 1'b1;
                                wr_addr <= ea;
                                wr_val  <= {sreg[14:0], sdi};
                                wr_pend <= 1'b1;
                            end
                            st <= E_IDLE;
                        end
                    end
                    E_READ: begin
                        sdo  <= sreg[15];   // msb first
                        sreg <= {sreg[14:0], 1'b0};
                    end
                    default: st <= E_IDLE;
                endcase
            end
        end
    end

    // low byte of each word at the even address
    always_ff @(posedge clk) begin
        if (mem_we)
            mem[mem_addr] <= mem_din;
        if (wr_stb) begin
            mem[{wr_addr, 1'b0}] <= wr_val[7:0];
            mem[{wr_addr, 1'b1}] <= wr_val[15:8];
        end
        mem_dout <= mem[mem_addr];
    end

endmodule

// File: rtl/main_bus.sv
`timescale 1ns/1ps

module main_bus #(
    parameter int EEP_WRITE_CYCLES = 4,
    parameter int RAM_ADDR_BITS    = 7
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  board_pkg::bus_req_t      req,
    output logic                     req_ready,
    output logic                     rsp_valid,
    output board_pkg::bus_rsp_t      rsp,
    input  logic                     rsp_ready,
    output board_pkg::ext_bus_t      ext,
    output logic                     rom_cs,
    output logic                     ram_cs,
    output logic                     pal_cs,
    output logic                     obj_cs,
    input  logic [15:0]              rom_data,
    input  logic                     rom_ok,
    input  logic [15:0]              ram_dout,
    input  logic                     ram_ok,
    input  logic [15:0]              pal_dout,
    input  logic [15:0]              obj_dout,
    input  logic [ 6:0]              joystick1,
    input  logic [ 6:0]              joystick2,
    input  logic [ 1:0]              cab_1p,
    input  logic [ 1:0]              coin,
    input  logic [ 1:0]              service,
    input  logic                     dip_test,
    input  logic                     lvbl,
    output logic [ 2:0]              cbnk,
    output logic                     dimpol,
    output logic                     dimmod,
    output logic [ 2:0]              dim,
    output logic                     rmrd,
    input  logic [RAM_ADDR_BITS-1:0] nv_addr,
    output logic [ 7:0]              nv_dout,
    input  logic [ 7:0]              nv_din,
    input  logic                     nv_we
);
    import board_pkg::*;

    iolo_t       iolo;
    iohi_t       iohi;
    logic [23:1] addr_q;
    logic [ 7:0] cab_dout;
    logic [15:0] wdata_q;
    logic        iolo_we;
    logic        iohi_we;
    logic        eep_do;
    logic        eep_rdy;

    assign cbnk   = iolo.cbnk;
    assign dimpol = iolo.dimpol;
    assign dimmod = iolo.dimmod;
    assign dim    = iohi.dim;
    assign rmrd   = iohi.rmrd;

    bus_cycle_ctrl u_ctrl (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .req_valid ( req_valid ),
        .req       ( req       ),
        .req_ready ( req_ready ),
        .rsp_valid ( rsp_valid ),
        .rsp       ( rsp       ),
        .rsp_ready ( rsp_ready ),
        .ext       ( ext       ),
        .addr_q    ( addr_q    ),
        .rom_cs    ( rom_cs    ),
        .ram_cs    ( ram_cs    ),
        .pal_cs    ( pal_cs    ),
        .obj_cs    ( obj_cs    ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .ram_dout  ( ram_dout  ),
        .ram_ok    ( ram_ok    ),
        .pal_dout  ( pal_dout  ),
        .obj_dout  ( obj_dout  ),
        .cab_dout  ( cab_dout  ),
        .iolo_we   ( iolo_we   ),
        .iohi_we   ( iohi_we   ),
        .wdata_q   ( wdata_q   )
    );

    cab_inputs u_cab (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .addr_q    ( addr_q    ),
        .joystick1 ( joystick1 ),
        .joystick2 ( joystick2 ),
        .cab_1p    ( cab_1p    ),
        .coin      ( coin      ),
        .service   ( service   ),
        .dip_test  ( dip_test  ),
        .lvbl      ( lvbl      ),
        .eep_do    ( eep_do    ),
        .eep_rdy   ( eep_rdy   ),
        .cab_dout  ( cab_dout  )
    );

    io_latches u_latch (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .iolo_we ( iolo_we ),
        .iohi_we ( iohi_we ),
        .wdata_q ( wdata_q ),
        .iolo    ( iolo    ),
        .iohi    ( iohi    )
    );

    // eeprom pins come straight off the low latch
    serial_eeprom #(
        .WRITE_CYCLES ( EEP_WRITE_CYCLES )
    ) u_eeprom (
        .clk      ( clk          ),
        .rst      ( rst          ),
        .sclk     ( iolo.eep_clk ),
        .scs      ( iolo.eep_cs  ),
        .sdi      ( iolo.eep_di  ),
        .sdo      ( eep_do       ),
        .rdy      ( eep_rdy      ),
        .mem_addr ( nv_addr      ),
        .mem_dout ( nv_dout      ),
        .mem_din  ( nv_din       ),
        .mem_we   ( nv_we        )
    );

endmodule

// File: bench/main_bus_props.sv
`timescale 1ns/1ps

module main_bus_props (
    input logic                clk,
    input logic                rst,
    input logic                req_ready,
    input logic                rsp_valid,
    input logic                rsp_ready,
    input board_pkg::bus_rsp_t rsp,
    input logic                rom_cs,
    input logic                ram_cs,
    input logic                pal_cs,
    input logic                obj_cs
);

    logic [3:0] cs_vec;

    assign cs_vec = {rom_cs, ram_cs, pal_cs, obj_cs};

    a_one_cs: assert property (@(posedge clk) disable iff (rst) $onehot0(cs_vec))
        else $error("more than one chip select high");

    // response held until taken
    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("response changed before it was taken");

    a_no_req: assert property (@(posedge clk) disable iff (rst) rsp_valid |-> !req_ready)
        else $error("request accepted while a response is pending");

    // selects low from reset on, whenever no slave access is on the bus
    a_idle_cs: assert property (@(posedge clk) disable iff (rst)
        req_ready || rsp_valid |-> cs_vec == 4'b0000)
        else $error("chip select high with no slave access in flight");

endmodule

bind main_bus main_bus_props u_props (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .req_ready ( req_ready ),
    .rsp_valid ( rsp_valid ),
    .rsp_ready ( rsp_ready ),
    .rsp       ( rsp       ),
    .rom_cs    ( rom_cs    ),
    .ram_cs    ( ram_cs    ),
    .pal_cs    ( pal_cs    ),
    .obj_cs    ( obj_cs    )
);

// File: bench/main_bus_tb.sv
`timescale 1ns/1ps

module main_bus_tb;
    import board_pkg::*;

    localparam int MAX_CYCLES = 20000;   // several times the full run

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        req_valid, req_ready, rsp_valid, rsp_ready;
    bus_req_t    req;
    bus_rsp_t    rsp;
    ext_bus_t    ext;
    logic        rom_cs, ram_cs, pal_cs, obj_cs;
    logic [15:0] rom_data, ram_dout, pal_dout, obj_dout;
    logic        rom_ok = 1'b0;
    logic        ram_ok = 1'b0;
    logic [ 6:0] joystick1, joystick2;
    logic [ 1:0] cab_1p, coin, service;
    logic        dip_test, lvbl;
    logic [ 2:0] cbnk, dim;
    logic        dimpol, dimmod, rmrd;
    logic [ 6:0] nv_addr;
    logic [ 7:0] nv_dout, nv_din;
    logic        nv_we;

    logic [15:0] rom_mem [0:255];
    logic [15:0] ram_mem [0:255];
    logic [15:0] ram_ref [0:255];   // expected ram contents
    logic [15:0] pal_mem [0:255];
    logic [15:0] obj_mem [0:255];
    logic [15:0] shadow  [0:63];    // expected eeprom words
    int          rom_cnt = 0;
    int          ram_cnt = 0;
    int          errors  = 0;
    int          cycles  = 0;
    bus_rsp_t    exp_q [$];
    string       name_q [$];
    bit          chk_q [$];
    bus_rsp_t    exp_head;
    string       name_head;
    bit          chk_head;
    logic        exp_do  = 1'b0;
    logic        ewen_model = 1'b0;
    logic [15:0] rd;
    logic [31:0] r;

    main_bus uut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // rom and ram answer after 0 to 5 cycles, the rest at once
    assign rom_data = rom_mem[ext.addr[8:1]];
    assign ram_dout = ram_mem[ext.addr[8:1]];
    assign pal_dout = pal_mem[ext.addr[8:1]];
    assign obj_dout = obj_mem[ext.addr[8:1]];

    always @(posedge clk) begin
        if (!rom_cs) begin
            rom_ok  <= 1'b0;
            rom_cnt <= int'($urandom_range(5, 0));
        end else if (rom_cnt == 0) rom_ok <= 1'b1;
        else rom_cnt <= rom_cnt - 1;
        if (!ram_cs) begin
            ram_ok  <= 1'b0;
            ram_cnt <= int'($urandom_range(5, 0));
        end else if (ram_cnt == 0) ram_ok <= 1'b1;
        else ram_cnt <= ram_cnt - 1;
        if (ram_cs && ram_ok && ext.we) begin
            if (!ext.dsn[1]) ram_mem[ext.addr[8:1]][15:8] <= ext.wdata[15:8];
            if (!ext.dsn[0]) ram_mem[ext.addr[8:1]][7:0] <= ext.wdata[7:0];
        end
    end

    function automatic logic [15:0] expect_read(input logic [23:0] baddr);
        logic [7:0] cab;
        case (baddr[2:1])
            2'd0: cab = {cab_1p[0], joystick1};
            2'd1: cab = {cab_1p[1], joystick2};
            2'd2: cab = {service, coin, 4'hf};
            // eeprom idle on every checked read
            default: cab = {dip_test, 3'b111, lvbl, 1'b1, 1'b1, exp_do};
        endcase
        if (baddr[23:20] == 4'h0) return rom_mem[baddr[8:1]];
        if (baddr[23:20] != 4'h1) return UNMAPPED_DATA;
        case (baddr[19:18])
            2'd0: return ram_ref[baddr[8:1]];
            2'd1: return pal_mem[baddr[8:1]];
            2'd2: return obj_mem[baddr[8:1]];
            default: return baddr[11:9] == 3'b000 ? {8'h00, cab} : UNMAPPED_DATA;
        endcase
    endfunction

    task automatic check_rdata(input string name, input bus_rsp_t e, input bus_rsp_t a);
        if (e !== a) begin
            $display("[ERROR] %s: expected %h, actual %h", name, e.rdata, a.rdata);
            errors++;
        end
    endtask

    task automatic check_latches(input string name, input iolo_t e_lo, input iohi_t e_hi);
        iolo_t a_lo;
        iohi_t a_hi;
        a_lo = '{cbnk: cbnk, dimpol: dimpol, dimmod: dimmod, default: 1'b0};
        a_hi = '{dim: dim, rmrd: rmrd};
        e_lo = {e_lo[7:3], 3'b000};   // eeprom pins have no top port
        if (a_lo !== e_lo || a_hi !== e_hi) begin
            $display("[ERROR] %s: expected %h/%h, actual %h/%h", name, e_lo, e_hi, a_lo, a_hi);
            errors++;
        end
    endtask

    task automatic check_nv(input string name, input logic [7:0] e, input logic [7:0] a);
        if (e !== a) begin
            $display("[ERROR] %s: expected %h, actual %h", name, e, a);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                $display("response arrived with no access outstanding");
                errors++;
            end else begin
                exp_head  = exp_q.pop_front();
                name_head = name_q.pop_front();
                chk_head  = chk_q.pop_front();
                if (chk_head) check_rdata(name_head, exp_head, rsp);
            end
        end
    end

    task automatic bus_access(input string name, input logic [23:0] baddr, input logic we,
                              input logic [15:0] wdata, input logic [1:0] dsn,
                              input bit chk, input bit stall, output logic [15:0] rdata);
        int waited;
        waited = 0;
        rdata  = UNMAPPED_DATA;
        exp_q.push_back('{rdata: expect_read(baddr)});
        name_q.push_back(name);
        chk_q.push_back(chk && !we);
        req_valid = 1'b1;
        req = '{addr: baddr[23:1], wdata: wdata, we: we, dsn: dsn};
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        rsp_ready = stall ? $urandom_range(3, 0) != 0 : 1'b1;   // random stalls
        while (!(rsp_valid && rsp_ready) && waited < 64) begin
            @(posedge clk);
            #1;
            rsp_ready = stall ? $urandom_range(3, 0) != 0 : 1'b1;
            waited++;
        end
        if (waited >= 64) begin
            $display("%s: no response within 64 cycles", name);
            errors++;
            void'(exp_q.pop_back());
            void'(name_q.pop_back());
            void'(chk_q.pop_back());
        end else begin
            rdata = rsp.rdata;
            @(posedge clk);
            #1;
        end
        rsp_ready = 1'b0;
    endtask

    task automatic set_cab_inputs();
        logic [31:0] v;
        v         = $urandom;
        joystick1 = v[6:0];
        joystick2 = v[13:7];
        cab_1p    = v[15:14];
        coin      = v[17:16];
        service   = v[19:18];
        dip_test  = v[20];
        lvbl      = v[21];
    endtask

    task automatic pins(input logic c, input logic s, input logic d);
        logic [15:0] q;
        bus_access("eeprom pins", 24'h1c0200, 1'b1, {13'h0, c, s, d}, 2'b00, 0, 0, q);
    endtask

    task automatic eep_bits(input logic [24:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            pins(1'b0, 1'b1, v[i]);
            pins(1'b1, 1'b1, v[i]);   // sampled on this rise
        end
    endtask

    task automatic eep_read(input string name, input logic [5:0] a);
        logic [15:0] q;
        pins(1'b0, 1'b1, 1'b0);
        eep_bits({16'h0, 1'b1, 2'b10, a}, 9);
        exp_do = 1'b0;   // dummy zero
        bus_access(name, 24'h1c0006, 1'b0, 16'h0, 2'b00, 1, 0, q);
        for (int k = 15; k >= 0; k--) begin
            pins(1'b0, 1'b1, 1'b0);
            pins(1'b1, 1'b1, 1'b0);
            exp_do = shadow[a][k];
            bus_access(name, 24'h1c0006, 1'b0, 16'h0, 2'b00, 1, 0, q);
        end
        pins(1'b0, 1'b0, 1'b0);
        exp_do = 1'b0;
    endtask

    task automatic eep_write(input logic [5:0] a, input logic [15:0] d);
        logic [15:0] q;
        int polls;
        polls = 0;
        pins(1'b0, 1'b1, 1'b0);
        eep_bits({1'b1, 2'b01, a, d}, 25);
        pins(1'b0, 1'b0, 1'b0);
        if (ewen_model) shadow[a] = d;
        q = 16'h0;
        while (!q[1] && polls < 20) begin   // wait for eep_rdy
            bus_access("eeprom poll", 24'h1c0006, 1'b0, 16'h0, 2'b00, 0, 0, q);
            polls++;
        end
        if (!q[1]) begin
            $display("eeprom stayed busy after a write to word %0d", a);
            errors++;
        end else if ((polls > 1) != ewen_model) begin
            // first poll lands inside the busy window of an accepted write
            $display("eeprom busy state wrong after a write to word %0d", a);
            errors++;
        end
    endtask

    task automatic eep_ext(input logic en);
        pins(1'b0, 1'b1, 1'b0);
        eep_bits({16'h0, 1'b1, 2'b00, en ? 6'b110000 : 6'b000000}, 9);
        pins(1'b0, 1'b0, 1'b0);
        ewen_model = en;
    endtask

    task automatic nv_write(input logic [6:0] a, input logic [7:0] d);
        nv_addr = a;
        nv_din  = d;
        nv_we   = 1'b1;
        @(posedge clk);
        #1;
        nv_we = 1'b0;
    endtask

    task automatic nv_check(input string name, input logic [6:0] a, input logic [7:0] e);
        nv_addr = a;
        @(posedge clk);
        #1;
        check_nv(name, e, nv_dout);
    endtask

    initial begin
        void'($urandom(32'h8e2265b8));
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        nv_addr   = '0;
        nv_din    = '0;
        nv_we     = 1'b0;
        set_cab_inputs();
        for (int i = 0; i < 256; i++) begin
            rom_mem[i] = 16'($urandom);
            ram_mem[i] = 16'($urandom);
            ram_ref[i] = ram_mem[i];
            pal_mem[i] = 16'($urandom);
            obj_mem[i] = 16'($urandom);
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        check_latches("latches after reset", '0, '0);
        if (!req_ready || rsp_valid || rom_cs || ram_cs || pal_cs || obj_cs) begin
            $display("handshake or chip selects not idle after reset");
            errors++;
        end

        // random reads across the four external slaves
        for (int i = 0; i < 48; i++) begin
            r = $urandom;
            bus_access("slave read", {r[9:8] == 2'd0 ? 4'h0 : 4'h1,
                r[9:8] == 2'd0 ? r[29:28] : r[9:8] - 2'd1, 9'h0, r[7:0], 1'b0},
                1'b0, 16'h0, 2'b11, 1, 1, rd);
        end

        for (int p = 0; p < 4; p++) begin   // every byte strobe pattern
            r = $urandom;
            bus_access("ram write", {4'h1, 11'h000, r[7:0], 1'b0}, 1'b1, r[31:16], 2'(p),
                       0, 1, rd);
            if (p[1] == 1'b0) ram_ref[r[7:0]][15:8] = r[31:24];
            if (p[0] == 1'b0) ram_ref[r[7:0]][7:0]  = r[23:16];
            bus_access("ram read back", {4'h1, 11'h000, r[7:0], 1'b0}, 1'b0, 16'h0, 2'b11,
                       1, 1, rd);
        end

        for (int i = 0; i < 16; i++) begin
            set_cab_inputs();
            bus_access("cabinet read", 24'h1c0000 | 24'(i % 4) << 1 | 24'(i / 8) << 8,
                       1'b0, 16'h0, 2'b11, 1, 0, rd);
        end
        bus_access("unmapped read", 24'h200000, 1'b0, 16'h0, 2'b11, 1, 0, rd);
        bus_access("unmapped read", 24'hf00010, 1'b0, 16'h0, 2'b11, 1, 0, rd);
        bus_access("unmapped read", 24'h1c0a00, 1'b0, 16'h0, 2'b11, 1, 0, rd);
        bus_access("latch read", 24'h1c0200, 1'b0, 16'h0, 2'b11, 1, 0, rd);

        r = $urandom & 32'hfffffff8;   // eeprom pins left low
        bus_access("low latch", 24'h1c0200, 1'b1, r[15:0], 2'b00, 0, 0, rd);
        check_latches("low latch", iolo_t'(r[7:0]), '0);
        bus_access("high latch", 24'h1c0300, 1'b1, r[31:16], 2'b00, 0, 0, rd);
        check_latches("high latch", iolo_t'(r[7:0]), iohi_t'(r[22:19]));

        for (int w = 5; w < 40; w += 5) begin   // dump port preload
            shadow[w] = 16'($urandom);
            nv_write({6'(w), 1'b0}, shadow[w][7:0]);
            nv_write({6'(w), 1'b1}, shadow[w][15:8]);
        end
        eep_read("eeprom preload read", 6'd5);
        eep_write(6'd10, 16'h1234);   // not enabled yet
        eep_read("eeprom locked write", 6'd10);
        eep_ext(1'b1);
        eep_write(6'd10, 16'ha5c3);
        eep_read("eeprom write", 6'd10);
        nv_check("dump low byte", 7'd20, shadow[10][7:0]);
        nv_check("dump high byte", 7'd21, shadow[10][15:8]);
        eep_ext(1'b0);
        eep_write(6'd20, 16'h0f0f);
        eep_read("eeprom after ewds", 6'd20);
        nv_check("dump after ewds", 7'd40, shadow[20][7:0]);

        repeat (4) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sources.f
rtl/board_pkg.sv
rtl/addr_decoder.sv
rtl/bus_cycle_ctrl.sv
rtl/cab_inputs.sv
rtl/io_latches.sv
rtl/serial_eeprom.sv
rtl/main_bus.sv
bench/main_bus_props.sv
bench/main_bus_tb.sv

// File: Makefile
VERILATOR  = verilator
TOP        = main_bus_tb
FILELIST   = sources.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert
LOG        = sim.log
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "\*\* PASS \*\*" $(LOG) && ! grep -q "\*\* FAIL \*\*" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
